/* dtm_params.svh */
// DTM build parameters
`ifndef DTM_PARAMS_SVH
`define DTM_PARAMS_SVH

// instruction register codes.
`define DTM_IR_IDCODE 5'h01
`define DTM_IR_DTMCS  5'h10
`define DTM_IR_DMI    5'h11
`define DTM_IR_BYPASS 5'h1f

// device identification word.
`define DTM_IDCODE 32'h1000_563d

// flops per level synchronizer, two or more.
`define DTM_SYNC_STAGE 2

// dtmcs version field, debug spec 0.13.
`define DTM_VERSION 4'd1

// dmi address width as reported in dtmcs.abits.
`define DTM_ABITS 6'd7

`endif

/* dtm_pkg.sv */
// DTM shared types
`default_nettype none

package dtm_pkg;

	typedef logic [6:0]  dmi_addr_t;
	typedef logic [31:0] dmi_data_t;
	typedef logic [1:0]  dmi_op_t;

	// request op codes and returned status codes.
	localparam dmi_op_t op_read     = 2'd1;
	localparam dmi_op_t op_write    = 2'd2;
	localparam dmi_op_t stat_ok     = 2'd0;
	localparam dmi_op_t stat_failed = 2'd2;
	localparam dmi_op_t stat_busy   = 2'd3;

	// same bit order as the dmi scan register.
	typedef struct packed {
		dmi_addr_t addr;
		dmi_data_t data;
		dmi_op_t   op;
	} dmi_req_t;

	typedef struct packed {
		dmi_data_t data;
		logic      err;
	} dmi_resp_t;

	typedef enum logic [3:0] {
		tlr, rti, sel_dr, cap_dr, shift_dr, ex1_dr, pause_dr, ex2_dr, upd_dr,
		sel_ir, cap_ir, shift_ir, ex1_ir, pause_ir, ex2_ir, upd_ir
	} tap_state_t;

	typedef enum logic [1:0] {ahb_idle, ahb_addr, ahb_data, ahb_ack} ahb_state_t;

endpackage

`default_nettype wire

/* dtm_level_sync.sv */
// Level synchronizer
`timescale 1ns/1ps
`default_nettype none
`include "dtm_params.svh"

module dtm_level_sync #(
	parameter int sync_stage = `DTM_SYNC_STAGE
) (
	input  logic clk,
	input  logic rst_n,
	input  logic d,
	output logic q
);

	logic [sync_stage-1:0] sync_q;

	// d enters at bit 0, q leaves from the top.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[sync_stage-2:0], d};
		end
	end

	assign q = sync_q[sync_stage-1];

endmodule

`default_nettype wire

/* dtm_rst_sync.sv */
// Reset synchronizer
`timescale 1ns/1ps
`default_nettype none

module dtm_rst_sync (
	input  logic clk,
	input  logic rst_n,
	output logic rst_sync_n
);

	logic [1:0] rst_q;

	// cleared while rst_n is low, then fills with ones.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rst_q <= 2'b00;
		end else begin
			rst_q <= {rst_q[0], 1'b1};
		end
	end

	// release follows two clean edges of this domain.
	assign rst_sync_n = rst_q[1];

endmodule

`default_nettype wire

/* dtm_tap.sv */
// JTAG TAP and DMI launch
`timescale 1ns/1ps
`default_nettype none
`include "dtm_params.svh"

module dtm_tap (
	input  logic               tck,
	input  logic               rst_n,
	input  logic               tms,
	input  logic               tdi,
	output logic               tdo,
	output logic               tdo_out_en,
	output logic               tap_req,
	output dtm_pkg::dmi_req_t  tap_req_data,
	input  logic               tap_ack,
	input  dtm_pkg::dmi_resp_t tap_resp
);

	localparam int dr_w = $bits(dtm_pkg::dmi_req_t);

	dtm_pkg::tap_state_t state;
	dtm_pkg::tap_state_t state_nxt;
	logic [4:0]          ir;
	logic [4:0]          ir_shift;
	logic [dr_w-1:0]     dr_shift;
	dtm_pkg::dmi_req_t   dr_req;
	dtm_pkg::dmi_addr_t  last_addr;
	dtm_pkg::dmi_data_t  last_data;
	dtm_pkg::dmi_op_t    dmi_stat;
	logic [31:0]         dtmcs;
	logic                busy;
	logic                sticky_busy;
	logic                sticky_err;
	logic                dmi_update;
	logic                launch;

	// IEEE 1149.1 state transitions.
	always_comb begin
		state_nxt = state;
		case (state)
			dtm_pkg::tlr:      state_nxt = tms ? dtm_pkg::tlr      : dtm_pkg::rti;
			dtm_pkg::rti:      state_nxt = tms ? dtm_pkg::sel_dr   : dtm_pkg::rti;
			dtm_pkg::sel_dr:   state_nxt = tms ? dtm_pkg::sel_ir   : dtm_pkg::cap_dr;
			dtm_pkg::cap_dr:   state_nxt = tms ? dtm_pkg::ex1_dr   : dtm_pkg::shift_dr;
			dtm_pkg::shift_dr: state_nxt = tms ? dtm_pkg::ex1_dr   : dtm_pkg::shift_dr;
			dtm_pkg::ex1_dr:   state_nxt = tms ? dtm_pkg::upd_dr   : dtm_pkg::pause_dr;
			dtm_pkg::pause_dr: state_nxt = tms ? dtm_pkg::ex2_dr   : dtm_pkg::pause_dr;
			dtm_pkg::ex2_dr:   state_nxt = tms ? dtm_pkg::upd_dr   : dtm_pkg::shift_dr;
			dtm_pkg::upd_dr:   state_nxt = tms ? dtm_pkg::sel_dr   : dtm_pkg::rti;
			dtm_pkg::sel_ir:   state_nxt = tms ? dtm_pkg::tlr      : dtm_pkg::cap_ir;
			dtm_pkg::cap_ir:   state_nxt = tms ? dtm_pkg::ex1_ir   : dtm_pkg::shift_ir;
			dtm_pkg::shift_ir: state_nxt = tms ? dtm_pkg::ex1_ir   : dtm_pkg::shift_ir;
			dtm_pkg::ex1_ir:   state_nxt = tms ? dtm_pkg::upd_ir   : dtm_pkg::pause_ir;
			dtm_pkg::pause_ir: state_nxt = tms ? dtm_pkg::ex2_ir   : dtm_pkg::pause_ir;
			dtm_pkg::ex2_ir:   state_nxt = tms ? dtm_pkg::upd_ir   : dtm_pkg::shift_ir;
			dtm_pkg::upd_ir:   state_nxt = tms ? dtm_pkg::sel_dr   : dtm_pkg::rti;
			default:           state_nxt = dtm_pkg::tlr;
		endcase
	end

	always_ff @(posedge tck) begin
		if (!rst_n) begin
			state <= dtm_pkg::tlr;
		end else begin
			state <= state_nxt;
		end
	end

	// instruction register, back to IDCODE in test-logic-reset.
	always_ff @(posedge tck) begin
		if (!rst_n) begin
			ir       <= `DTM_IR_IDCODE;
			ir_shift <= '0;
		end else begin
			case (state)
				dtm_pkg::tlr:      ir       <= `DTM_IR_IDCODE;
				dtm_pkg::cap_ir:   ir_shift <= 5'b00001;
				dtm_pkg::shift_ir: ir_shift <= {tdi, ir_shift[4:1]};
				dtm_pkg::upd_ir:   ir       <= ir_shift;
				default:           ir       <= ir;
			endcase
		end
	end

	assign dmi_stat = (busy || sticky_busy) ? dtm_pkg::stat_busy :
			sticky_err ? dtm_pkg::stat_failed : dtm_pkg::stat_ok;

	assign dtmcs = {20'b0, dmi_stat, `DTM_ABITS, `DTM_VERSION};

	// one shared shift register, its active length set by the IR.
	always_ff @(posedge tck) begin
		if (state == dtm_pkg::cap_dr) begin
			case (ir)
				`DTM_IR_IDCODE: dr_shift <= dr_w'(`DTM_IDCODE);
				`DTM_IR_DTMCS:  dr_shift <= dr_w'(dtmcs);
				`DTM_IR_DMI:    dr_shift <= {last_addr, last_data, dmi_stat};
				default:        dr_shift <= '0;
			endcase
		end else if (state == dtm_pkg::shift_dr) begin
			case (ir)
				`DTM_IR_DMI:                  dr_shift <= {tdi, dr_shift[dr_w-1:1]};
				`DTM_IR_IDCODE, `DTM_IR_DTMCS: dr_shift[31:0] <= {tdi, dr_shift[31:1]};
				default:                      dr_shift[0] <= tdi;
			endcase
		end
	end

	assign dr_req     = dr_shift;
	assign dmi_update = (state == dtm_pkg::upd_dr) && (ir == `DTM_IR_DMI);
	assign launch     = dmi_update && !busy &&
			(dr_req.op == dtm_pkg::op_read || dr_req.op == dtm_pkg::op_write);

	// busy spans req high through ack seen low again.
	always_ff @(posedge tck) begin
		if (!rst_n) begin
			tap_req     <= 1'b0;
			busy        <= 1'b0;
			sticky_busy <= 1'b0;
			sticky_err  <= 1'b0;
			last_addr   <= '0;
			last_data   <= '0;
		end else begin
			if (launch) begin
				tap_req   <= 1'b1;
				busy      <= 1'b1;
				last_addr <= dr_req.addr;
			end else if (tap_req && tap_ack) begin
				tap_req   <= 1'b0;
				last_data <= tap_resp.data;
				if (tap_resp.err) begin
					sticky_err <= 1'b1;
				end
			end else if (busy && !tap_ack) begin
				busy <= tap_req;
			end
			if (dmi_update && busy) begin
				sticky_busy <= 1'b1;
			end
			// dtmcs.dmireset.
			if (state == dtm_pkg::upd_dr && ir == `DTM_IR_DTMCS && dr_shift[16]) begin
				sticky_busy <= 1'b0;
				sticky_err  <= 1'b0;
			end
		end
	end

	always_ff @(posedge tck) begin
		if (launch) begin
			tap_req_data <= dr_req;
		end
	end

	// tdo changes on the falling edge.
	always_ff @(negedge tck) begin
		if (!rst_n) begin
			tdo <= 1'b0;
		end else if (state == dtm_pkg::shift_ir) begin
			tdo <= ir_shift[0];
		end else if (state == dtm_pkg::shift_dr) begin
			tdo <= dr_shift[0];
		end
	end

	assign tdo_out_en = (state == dtm_pkg::shift_ir) || (state == dtm_pkg::shift_dr);

endmodule

`default_nettype wire

/* dtm_dmi_ahb.sv */
// DMI to AHB-Lite master
`timescale 1ns/1ps
`default_nettype none

module dtm_dmi_ahb (
	input  logic               hclk,
	input  logic               rst_n,
	input  logic               dmi_req,
	input  dtm_pkg::dmi_req_t  dmi_req_data,
	output logic               dmi_ack,
	output dtm_pkg::dmi_resp_t dmi_resp,
	output logic               dmi_hsel,
	output logic               dmi_hwrite,
	output logic [1:0]         dmi_htrans,
	output logic [31:0]        dmi_haddr,
	output logic [31:0]        dmi_hwdata,
	output logic [2:0]         dmi_hsize,
	output logic [2:0]         dmi_hburst,
	output logic [3:0]         dmi_hprot,
	input  logic [31:0]        dmi_hrdata,
	input  logic               dmi_hready,
	input  logic               dmi_hresp
);

	localparam logic [1:0] htrans_idle   = 2'b00;
	localparam logic [1:0] htrans_nonseq = 2'b10;

	dtm_pkg::ahb_state_t state;
	logic                start;
	logic                addr_done;
	logic                data_done;

	// single word, data access, privileged.
	assign dmi_hsize  = 3'b010;
	assign dmi_hburst = 3'b000;
	assign dmi_hprot  = 4'b0011;

	assign start     = (state == dtm_pkg::ahb_idle) && dmi_req && !dmi_ack;
	assign addr_done = (state == dtm_pkg::ahb_addr) && dmi_hready;
	assign data_done = (state == dtm_pkg::ahb_data) && dmi_hready;

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			state      <= dtm_pkg::ahb_idle;
			dmi_hsel   <= 1'b0;
			dmi_htrans <= htrans_idle;
			dmi_haddr  <= '0;
			dmi_hwrite <= 1'b0;
			dmi_ack    <= 1'b0;
		end else begin
			case (state)
				dtm_pkg::ahb_idle: begin
					if (start) begin
						dmi_hsel   <= 1'b1;
						dmi_htrans <= htrans_nonseq;
						// dmi registers are word indexed.
						dmi_haddr  <= {23'b0, dmi_req_data.addr, 2'b00};
						dmi_hwrite <= (dmi_req_data.op == dtm_pkg::op_write);
						state      <= dtm_pkg::ahb_addr;
					end
				end
				dtm_pkg::ahb_addr: begin
					// address phase held until the bus takes it.
					if (addr_done) begin
						dmi_hsel   <= 1'b0;
						dmi_htrans <= htrans_idle;
						state      <= dtm_pkg::ahb_data;
					end
				end
				dtm_pkg::ahb_data: begin
					if (data_done) begin
						dmi_ack <= 1'b1;
						state   <= dtm_pkg::ahb_ack;
					end
				end
				dtm_pkg::ahb_ack: begin
					// wait for the tck side to drop req.
					if (!dmi_req) begin
						dmi_ack <= 1'b0;
						state   <= dtm_pkg::ahb_idle;
					end
				end
				default: begin
					state <= dtm_pkg::ahb_idle;
				end
			endcase
		end
	end

	// request payload is stable while dmi_req is high.
	always_ff @(posedge hclk) begin
		if (addr_done) begin
			dmi_hwdata <= dmi_req_data.data;
		end
	end

	// response is held until the next transfer completes.
	always_ff @(posedge hclk) begin
		if (data_done) begin
			dmi_resp.err <= dmi_hresp;
			if (!dmi_hwrite) begin
				dmi_resp.data <= dmi_hrdata;
			end
		end
	end

endmodule

`default_nettype wire

/* dtm_top.sv */
// JTAG debug transport top
`timescale 1ns/1ps
`default_nettype none
`include "dtm_params.svh"

module dtm_top #(
	parameter int sync_stage = `DTM_SYNC_STAGE
) (
	input  logic        rst_n,
	input  logic        tck,
	input  logic        tms,
	input  logic        tdi,
	output logic        tdo,
	output logic        tdo_out_en,
	input  logic        dmi_hclk,
	output logic        dmi_hresetn,
	output logic        dmi_hsel,
	output logic [1:0]  dmi_htrans,
	output logic [31:0] dmi_haddr,
	output logic [2:0]  dmi_hsize,
	output logic [2:0]  dmi_hburst,
	output logic [3:0]  dmi_hprot,
	output logic [31:0] dmi_hwdata,
	output logic        dmi_hwrite,
	input  logic [31:0] dmi_hrdata,
	input  logic        dmi_hready,
	input  logic        dmi_hresp
);

	logic               tck_rst_n;
	logic               tap_req;
	logic               tap_ack;
	dtm_pkg::dmi_req_t  tap_req_data;
	logic               dmi_req;
	logic               dmi_ack;
	dtm_pkg::dmi_resp_t dmi_resp;

	dtm_rst_sync tck_rst_i (.clk(tck), .rst_n(rst_n), .rst_sync_n(tck_rst_n));

	dtm_rst_sync hclk_rst_i (.clk(dmi_hclk), .rst_n(rst_n), .rst_sync_n(dmi_hresetn));

	dtm_tap tap_i (
		.tck         (tck),
		.rst_n       (tck_rst_n),
		.tms         (tms),
		.tdi         (tdi),
		.tdo         (tdo),
		.tdo_out_en  (tdo_out_en),
		.tap_req     (tap_req),
		.tap_req_data(tap_req_data),
		.tap_ack     (tap_ack),
		.tap_resp    (dmi_resp)
	);

	// handshake levels only, payloads cross unsynchronized.
	dtm_level_sync #(.sync_stage(sync_stage)) req_sync_i (
		.clk  (dmi_hclk),
		.rst_n(dmi_hresetn),
		.d    (tap_req),
		.q    (dmi_req)
	);

	dtm_level_sync #(.sync_stage(sync_stage)) ack_sync_i (
		.clk  (tck),
		.rst_n(tck_rst_n),
		.d    (dmi_ack),
		.q    (tap_ack)
	);

	dtm_dmi_ahb dmi_i (
		.hclk        (dmi_hclk),
		.rst_n       (dmi_hresetn),
		.dmi_req     (dmi_req),
		.dmi_req_data(tap_req_data),
		.dmi_ack     (dmi_ack),
		.dmi_resp    (dmi_resp),
		.dmi_hsel    (dmi_hsel),
		.dmi_hwrite  (dmi_hwrite),
		.dmi_htrans  (dmi_htrans),
		.dmi_haddr   (dmi_haddr),
		.dmi_hwdata  (dmi_hwdata),
		.dmi_hsize   (dmi_hsize),
		.dmi_hburst  (dmi_hburst),
		.dmi_hprot   (dmi_hprot),
		.dmi_hrdata  (dmi_hrdata),
		.dmi_hready  (dmi_hready),
		.dmi_hresp   (dmi_hresp)
	);

endmodule

`default_nettype wire

/* dtm_chk.sv */
// DTM protocol assertions
`timescale 1ns/1ps
`default_nettype none

module dtm_chk (
	input logic        tck,
	input logic        tck_rst_n,
	input logic        dmi_hclk,
	input logic        dmi_hresetn,
	input logic        tap_req,
	input logic        tap_ack,
	input logic        dmi_req,
	input logic        dmi_ack,
	input logic [1:0]  dmi_htrans,
	input logic [31:0] dmi_haddr,
	input logic        dmi_hwrite,
	input logic        dmi_hready,
	input logic        tms,
	input logic        tdo_out_en
);

	int fail_cnt = 0;

	// req only rises once the previous ack has dropped.
	req_after_ack_low: assert property (@(posedge tck) disable iff (!tck_rst_n)
		$rose(tap_req) |-> !$past(tap_ack))
	else begin
		$error("tap_req rose while tap_ack was still high");
		fail_cnt++;
	end

	ack_needs_req: assert property (@(posedge dmi_hclk) disable iff (!dmi_hresetn)
		$rose(dmi_ack) |-> $past(dmi_req))
	else begin
		$error("dmi_ack rose without dmi_req");
		fail_cnt++;
	end

	// wait states freeze the bus.
	addr_held_on_wait: assert property (@(posedge dmi_hclk) disable iff (!dmi_hresetn)
		!dmi_hready |=> $stable(dmi_haddr) && $stable(dmi_hwrite) && $stable(dmi_htrans))
	else begin
		$error("AHB address phase changed while hready was low");
		fail_cnt++;
	end

	// shift states are only entered or held with tms low.
	tdo_en_only_in_shift: assert property (@(posedge tck) disable iff (!tck_rst_n)
		tdo_out_en |-> !$past(tms))
	else begin
		$error("tdo_out_en high outside the shift states");
		fail_cnt++;
	end

endmodule

bind dtm_top dtm_chk chk_i (
	.tck        (tck),
	.tck_rst_n  (tck_rst_n),
	.dmi_hclk   (dmi_hclk),
	.dmi_hresetn(dmi_hresetn),
	.tap_req    (tap_req),
	.tap_ack    (tap_ack),
	.dmi_req    (dmi_req),
	.dmi_ack    (dmi_ack),
	.dmi_htrans (dmi_htrans),
	.dmi_haddr  (dmi_haddr),
	.dmi_hwrite (dmi_hwrite),
	.dmi_hready (dmi_hready),
	.tms        (tms),
	.tdo_out_en (tdo_out_en)
);

`default_nettype wire

/* tb_dtm_top.sv */
// DTM testbench
`timescale 1ns/1ps
`default_nettype none
`include "dtm_params.svh"

module tb_dtm_top;

	// scan cycles of all tests plus an allowance for each handshake wait.
	localparam int scan_cycles = 751;
	localparam int wait_cycles = 150;
	localparam int cycle_limit = (scan_cycles + wait_cycles) * 3 / 2;

	logic        rst_n;
	logic        tck;
	logic        tms;
	logic        tdi;
	logic        tdo;
	logic        tdo_out_en;
	logic        dmi_hclk;
	logic        dmi_hresetn;
	logic        dmi_hsel;
	logic [1:0]  dmi_htrans;
	logic [31:0] dmi_haddr;
	logic [2:0]  dmi_hsize;
	logic [2:0]  dmi_hburst;
	logic [3:0]  dmi_hprot;
	logic [31:0] dmi_hwdata;
	logic        dmi_hwrite;
	logic [31:0] dmi_hrdata;
	logic        dmi_hready;
	logic        dmi_hresp;

	logic [31:0] mem [0:63];
	logic        dph_valid;
	logic        dph_write;
	logic        dph_err;
	logic [31:0] dph_addr;
	int          wait_left;
	logic        long_stall;
	logic [31:0] xfer_addr [$];
	logic        xfer_write [$];
	integer      seed;
	int          cycle_cnt = 0;
	int          checks = 0;
	int          test_errs = 0;
	int          total_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	dtm_top dut_i (.*);

	always #10 dmi_hclk = ~dmi_hclk;
	always #30 tck = ~tck;

	always @(posedge tck) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d tck cycles, a DMI handshake never finished", cycle_cnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] fill_word(input int idx);
		return 32'hbeef_0000 | 32'(idx);
	endfunction

	// word memory, error at byte address 0x100 and above.
	always @(posedge dmi_hclk) begin
		if (!dmi_hresetn) begin
			dph_valid = 1'b0;
		end else begin
			if (dph_valid && dmi_hready) begin
				if (dph_write && !dph_err) begin
					mem[dph_addr[7:2]] = dmi_hwdata;
				end
				dph_valid = 1'b0;
			end
			if (dmi_hsel && dmi_htrans == 2'b10 && dmi_hready) begin
				dph_valid = 1'b1;
				dph_write = dmi_hwrite;
				dph_addr  = dmi_haddr;
				dph_err   = (dmi_haddr >= 32'h100);
				wait_left = long_stall ? 200 : ($random(seed) & 3);
				xfer_addr.push_back(dmi_haddr);
				xfer_write.push_back(dmi_hwrite);
				// single word transfer, privileged data access.
				check_value("hsize word", dmi_hsize, 3'b010);
				check_value("hburst single", dmi_hburst, 3'b000);
				check_value("hprot data privileged", dmi_hprot, 4'b0011);
			end
		end
		#2;
		if (dph_valid && wait_left > 0) begin
			dmi_hready = 1'b0;
			wait_left--;
		end else begin
			dmi_hready = 1'b1;
			dmi_hresp  = dph_valid && dph_err;
			dmi_hrdata = (dph_valid && !dph_err) ? mem[dph_addr[7:2]] : 32'h0;
		end
	end

	task automatic tck_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
		tms = tms_v;
		tdi = tdi_v;
		@(posedge tck);
		tdo_v = tdo;
		#2;
	endtask

	// from run-test-idle back to run-test-idle.
	task automatic ir_scan(input logic [4:0] ir_v);
		logic b;
		tck_step(1'b1, 1'b0, b);
		tck_step(1'b1, 1'b0, b);
		tck_step(1'b0, 1'b0, b);
		tck_step(1'b0, 1'b0, b);
		for (int i = 0; i < 5; i++) begin
			tck_step(i == 4, ir_v[i], b);
		end
		tck_step(1'b1, 1'b0, b);
		tck_step(1'b0, 1'b0, b);
	endtask

	task automatic dr_scan(input int len, input logic [40:0] din, output logic [40:0] dout);
		logic b;
		dout = '0;
		tck_step(1'b1, 1'b0, b);
		tck_step(1'b0, 1'b0, b);
		tck_step(1'b0, 1'b0, b);
		for (int i = 0; i < len; i++) begin
			tck_step(i == len - 1, din[i], b);
			dout[i] = b;
		end
		tck_step(1'b1, 1'b0, b);
		tck_step(1'b0, 1'b0, b);
	endtask

	task automatic dmi_scan(input dtm_pkg::dmi_addr_t addr, input dtm_pkg::dmi_data_t data,
			input dtm_pkg::dmi_op_t op, output dtm_pkg::dmi_req_t cap);
		logic [40:0] raw;
		dr_scan(41, {addr, data, op}, raw);
		cap = raw;
	endtask

	// idle in run-test-idle until req and ack are both low.
	task automatic wait_ready();
		logic b;
		while (dut_i.tap_req || dut_i.tap_ack) begin
			tck_step(1'b0, 1'b0, b);
		end
		tck_step(1'b0, 1'b0, b);
	endtask

	task automatic check_value(input string what, input logic [40:0] got,
			input logic [40:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d mismatches", tests_run, name, test_errs);
			tests_failed++;
		end
		total_errs += test_errs;
		test_errs = 0;
	endtask

	initial begin
		dtm_pkg::dmi_req_t  cap;
		dtm_pkg::dmi_addr_t a;
		dtm_pkg::dmi_addr_t b_addr;
		logic [40:0]        raw;
		logic [31:0]        wdata;
		logic               b;
		int                 n;
		seed       = 32'h90d;
		dmi_hclk   = 1'b0;
		tck        = 1'b1;
		rst_n      = 1'b0;
		tms        = 1'b1;
		tdi        = 1'b0;
		dmi_hrdata = 32'h0;
		dmi_hready = 1'b1;
		dmi_hresp  = 1'b0;
		dph_valid  = 1'b0;
		long_stall = 1'b0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = fill_word(i);
		end
		repeat (8) @(posedge dmi_hclk);
		#2 rst_n = 1'b1;
		check_value("dmi_hresetn in reset", dmi_hresetn, 1'b0);
		@(posedge tck);
		#2;
		repeat (5) tck_step(1'b1, 1'b0, b);
		tck_step(1'b0, 1'b0, b);
		check_value("dmi_hresetn released", dmi_hresetn, 1'b1);

		dr_scan(32, '0, raw);
		check_value("idcode", raw[31:0], `DTM_IDCODE);
		end_test("idcode after reset");

		ir_scan(`DTM_IR_DTMCS);
		dr_scan(32, '0, raw);
		check_value("dtmcs version", raw[3:0], `DTM_VERSION);
		check_value("dtmcs abits", raw[9:4], 6'd7);
		check_value("dtmcs dmistat", raw[11:10], 2'd0);
		ir_scan(`DTM_IR_BYPASS);
		dr_scan(8, 41'h0b4, raw);
		check_value("bypass delay", raw[7:0], {7'h34, 1'b0});
		end_test("dtmcs and bypass");

		ir_scan(`DTM_IR_DMI);
		a = 7'h15;
		wdata = $random(seed);
		xfer_addr.delete();
		xfer_write.delete();
		dmi_scan(a, wdata, dtm_pkg::op_write, cap);
		wait_ready();
		dmi_scan(a, 32'h0, dtm_pkg::op_read, cap);
		wait_ready();
		dmi_scan(7'h0, 32'h0, 2'd0, cap);
		check_value("transfer count", xfer_addr.size(), 2);
		check_value("write address", xfer_addr[0], 32'(a) * 4);
		check_value("write flag", xfer_write[0], 1'b1);
		check_value("read address", xfer_addr[1], 32'(a) * 4);
		check_value("read flag", xfer_write[1], 1'b0);
		check_value("read back address", cap.addr, a);
		check_value("read back data", cap.data, wdata);
		check_value("read back status", cap.op, 2'd0);
		end_test("dmi write then read");

		dmi_scan(7'h40, 32'h0, dtm_pkg::op_read, cap);
		wait_ready();
		dmi_scan(7'h0, 32'h0, 2'd0, cap);
		check_value("error status", cap.op, 2'd2);
		dmi_scan(7'h0, 32'h0, 2'd0, cap);
		check_value("error status held", cap.op, 2'd2);
		ir_scan(`DTM_IR_DTMCS);
		dr_scan(32, 41'h1_0000, raw);
		check_value("dtmcs dmistat on error", raw[11:10], 2'd2);
		ir_scan(`DTM_IR_DMI);
		dmi_scan(7'h0, 32'h0, 2'd0, cap);
		check_value("status after dmireset", cap.op, 2'd0);
		end_test("dmi error sticky");

		// a long data phase keeps the first request in flight.
		b_addr = 7'h2a;
		n = xfer_addr.size();
		long_stall = 1'b1;
		dmi_scan(b_addr, 32'h0, dtm_pkg::op_read, cap);
		dmi_scan(b_addr, ~wdata, dtm_pkg::op_write, cap);
		check_value("busy capture", cap.op, 2'd3);
		wait_ready();
		long_stall = 1'b0;
		dmi_scan(7'h0, 32'h0, 2'd0, cap);
		check_value("busy status held", cap.op, 2'd3);
		check_value("stalled read data", cap.data, fill_word(b_addr));
		check_value("transfers issued", xfer_addr.size(), n + 1);
		check_value("memory untouched", mem[b_addr], fill_word(b_addr));
		ir_scan(`DTM_IR_DTMCS);
		dr_scan(32, 41'h1_0000, raw);
		ir_scan(`DTM_IR_DMI);
		dmi_scan(7'h0, 32'h0, 2'd0, cap);
		check_value("status after busy clear", cap.op, 2'd0);
		end_test("dmi busy sticky");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion errors",
			tests_run, tests_failed, checks, total_errs, dut_i.chk_i.fail_cnt);
		if (tests_failed == 0 && dut_i.chk_i.fail_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dtm_top.f */
+incdir+.
dtm_pkg.sv
dtm_level_sync.sv
dtm_rst_sync.sv
dtm_tap.sv
dtm_dmi_ahb.sv
dtm_top.sv
dtm_chk.sv
tb_dtm_top.sv

/* Bender.yml */
package:
  name: jtag_dtm

export_include_dirs:
  - .

sources:
  - dtm_pkg.sv
  - dtm_level_sync.sv
  - dtm_rst_sync.sv
  - dtm_tap.sv
  - dtm_dmi_ahb.sv
  - dtm_top.sv
  - target: test
    files:
      - dtm_chk.sv
      - tb_dtm_top.sv
